//--- common/wb_pkg.sv
//****************************************
// Shared definitions for the write-back arbiter
// Unit count, tag and address widths,
// data word and CR field types,
// XER address and CR condition codes
//****************************************

package wb_pkg;

    // Number of GPR producing execution units
    localparam int NUM_UNITS = 8;
    localparam int UNIT_IDX_W = $clog2(NUM_UNITS);
    localparam int RS_ID_W = 5;

    typedef logic [0:UNIT_IDX_W-1] unit_idx_t;
    typedef logic [0:RS_ID_W-1]    rs_id_t;
    typedef logic [0:4]            gpr_addr_t;
    typedef logic [0:9]            spr_addr_t;
    // Bit 0 is the most significant bit
    typedef logic [0:31]           word_t;
    // LT, GT, EQ, SO in that order
    typedef logic [0:3]            cr_field_t;

    // XER lives at SPR number 1
    localparam spr_addr_t XER_ADDR = 10'd1;

    // Condition codes, SO bit is appended behind them
    localparam logic [0:2] CR_LT = 3'b100;
    localparam logic [0:2] CR_GT = 3'b010;
    localparam logic [0:2] CR_EQ = 3'b001;

endpackage

//--- common/wb_search_if.sv
//****************************************
// Round-robin search results from the
// unit search to the grant controller
//****************************************

`timescale 1ns/1ps

interface wb_search_if;
    import wb_pkg::*;

    // First valid unit from the pointer on
    logic      any_valid;
    unit_idx_t next_idx;
    // First valid unit without an XER update
    logic      clean_valid;
    unit_idx_t clean_idx;

    modport search (output any_valid, next_idx, clean_valid, clean_idx);
    modport ctrl   (input  any_valid, next_idx, clean_valid, clean_idx);

endinterface

//--- common/wb_grant_if.sv
//****************************************
// Grant decision from the grant controller
// to the search pointer and result stage
//****************************************

`timescale 1ns/1ps

interface wb_grant_if;
    import wb_pkg::*;

    logic      grant_gpr;
    unit_idx_t gpr_idx;
    logic      grant_spr;
    // Current SPR turn flag, observed by checkers
    logic      spr_turn;

    modport ctrl   (output grant_gpr, gpr_idx, grant_spr, spr_turn);
    modport search (input  grant_gpr, gpr_idx);
    modport stage  (input  grant_gpr, gpr_idx, grant_spr);

endinterface

//--- hw/wb_unit_search.sv
//****************************************
// Round-robin pointer over the GPR units
// Circular priority search over all valid
// units and over units without XER update
//****************************************

`timescale 1ns/1ps

module wb_unit_search (
    input  logic        clk,
    input  logic        rst,
    input  logic        gpr_valid     [0:wb_pkg::NUM_UNITS-1],
    input  logic        gpr_xer_valid [0:wb_pkg::NUM_UNITS-1],
    wb_grant_if.search  grant,
    wb_search_if.search found
);
    import wb_pkg::*;

    unit_idx_t ptr;

    // Pointer follows the last granted unit
    always_ff @(posedge clk) begin
        if (rst) begin
            ptr <= '0;
        end else if (grant.grant_gpr) begin
            ptr <= grant.gpr_idx;
        end
    end

    // Both searches start at the pointer itself and wrap around
    always_comb begin
        unit_idx_t idx;
        logic      hit_any;
        logic      hit_clean;

        hit_any         = 1'b0;
        hit_clean       = 1'b0;
        found.next_idx  = ptr;
        found.clean_idx = ptr;

        for (int i = 0; i < NUM_UNITS; i++) begin
            idx = unit_idx_t'((int'(ptr) + i) % NUM_UNITS);

            if (gpr_valid[idx] && !hit_any) begin
                found.next_idx = idx;
                hit_any        = 1'b1;
            end

            // Units that leave the SPR port free
            if (gpr_valid[idx] && !gpr_xer_valid[idx] && !hit_clean) begin
                found.clean_idx = idx;
                hit_clean       = 1'b1;
            end
        end

        found.any_valid   = hit_any;
        found.clean_valid = hit_clean;
    end

endmodule

//--- hw/wb_grant_ctrl.sv
//****************************************
// SPR versus GPR grant decision
// Alternating turn flag keeps the SPR
// unit and the GPR units from starving
//****************************************

`timescale 1ns/1ps

module wb_grant_ctrl (
    input  logic      clk,
    input  logic      rst,
    input  logic      spr_valid,
    wb_search_if.ctrl found,
    wb_grant_if.ctrl  grant
);
    import wb_pkg::*;

    logic      spr_turn;
    logic      spr_turn_next;
    logic      take_gpr;
    logic      take_spr;
    unit_idx_t take_idx;

    always_comb begin
        take_gpr      = 1'b0;
        take_spr      = 1'b0;
        take_idx      = found.next_idx;
        spr_turn_next = spr_turn;

        if (!spr_valid) begin
            // Only GPR traffic, flag untouched
            take_gpr = found.any_valid;
            take_idx = found.next_idx;
        end else if (spr_turn) begin
            // SPR owns this cycle, a GPR without XER may ride along
            take_spr      = 1'b1;
            take_gpr      = found.clean_valid;
            take_idx      = found.clean_idx;
            spr_turn_next = 1'b0;
        end else begin
            spr_turn_next = 1'b1;

            if (found.clean_valid) begin
                // No conflict on the SPR port, serve both
                take_gpr = 1'b1;
                take_idx = found.clean_idx;
                take_spr = 1'b1;
            end else if (found.any_valid) begin
                // Every valid unit writes XER, GPR goes first
                take_gpr = 1'b1;
                take_idx = found.next_idx;
            end else begin
                take_spr = 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            spr_turn <= 1'b0;
        end else begin
            spr_turn <= spr_turn_next;
        end
    end

    assign grant.grant_gpr = take_gpr;
    assign grant.gpr_idx   = take_idx;
    assign grant.grant_spr = take_spr;
    assign grant.spr_turn  = spr_turn;

endmodule

//--- hw/wb_result_stage.sv
//****************************************
// Ready generation from the grant
// Result multiplexing and CR0 computation
// Registered GPR, SPR and CR write ports
//****************************************

`timescale 1ns/1ps

module wb_result_stage (
    input  logic                clk,
    input  logic                rst,
    wb_grant_if.stage           grant,

    input  wb_pkg::rs_id_t      gpr_rs_id     [0:wb_pkg::NUM_UNITS-1],
    input  wb_pkg::gpr_addr_t   gpr_reg_addr  [0:wb_pkg::NUM_UNITS-1],
    input  wb_pkg::word_t       gpr_result    [0:wb_pkg::NUM_UNITS-1],
    input  logic                gpr_xer_valid [0:wb_pkg::NUM_UNITS-1],
    input  wb_pkg::word_t       gpr_xer       [0:wb_pkg::NUM_UNITS-1],
    input  logic                gpr_cr0_valid [0:wb_pkg::NUM_UNITS-1],
    input  logic                gpr_so        [0:wb_pkg::NUM_UNITS-1],
    output logic                gpr_ready     [0:wb_pkg::NUM_UNITS-1],

    input  wb_pkg::rs_id_t      spr_rs_id,
    input  wb_pkg::spr_addr_t   spr_reg_addr,
    input  wb_pkg::word_t       spr_result,
    output logic                spr_ready,

    output logic                wb_gpr_valid,
    output wb_pkg::rs_id_t      wb_gpr_rs_id,
    output wb_pkg::gpr_addr_t   wb_gpr_reg_addr,
    output wb_pkg::word_t       wb_gpr_result,

    output logic                wb_spr_valid,
    output wb_pkg::rs_id_t      wb_spr_rs_id,
    output wb_pkg::spr_addr_t   wb_spr_reg_addr,
    output wb_pkg::word_t       wb_spr_result,

    output logic                wb_cr_valid,
    output wb_pkg::rs_id_t      wb_cr_rs_id,
    output wb_pkg::cr_field_t   wb_cr_field
);
    import wb_pkg::*;

    unit_idx_t sel;
    logic      xer_take;
    logic      spr_take;
    logic      cr_take;

    // Signed view of the result, bit 0 is the sign
    function automatic cr_field_t cr0_field(input word_t res, input logic so);
        if (res[0]) begin
            return {CR_LT, so};
        end else if (res == '0) begin
            return {CR_EQ, so};
        end
        return {CR_GT, so};
    endfunction

    assign sel = grant.gpr_idx;

    // One-hot ready towards the granted unit
    always_comb begin
        for (int i = 0; i < NUM_UNITS; i++) begin
            gpr_ready[i] = grant.grant_gpr && (sel == unit_idx_t'(i));
        end
    end

    assign spr_ready = grant.grant_spr;

    // XER update shares the SPR port, the grant keeps them apart
    assign xer_take = grant.grant_gpr && gpr_xer_valid[sel];
    assign spr_take = xer_take || grant.grant_spr;
    assign cr_take  = grant.grant_gpr && gpr_cr0_valid[sel];

    always_ff @(posedge clk) begin
        if (rst) begin
            wb_gpr_valid <= 1'b0;
            wb_spr_valid <= 1'b0;
            wb_cr_valid  <= 1'b0;
        end else begin
            wb_gpr_valid <= grant.grant_gpr;
            wb_spr_valid <= spr_take;
            wb_cr_valid  <= cr_take;
        end
    end

    always_ff @(posedge clk) begin
        if (grant.grant_gpr) begin
            wb_gpr_rs_id    <= gpr_rs_id[sel];
            wb_gpr_reg_addr <= gpr_reg_addr[sel];
            wb_gpr_result   <= gpr_result[sel];
        end
        if (xer_take) begin
            wb_spr_rs_id    <= gpr_rs_id[sel];
            wb_spr_reg_addr <= XER_ADDR;
            wb_spr_result   <= gpr_xer[sel];
        end else if (grant.grant_spr) begin
            wb_spr_rs_id    <= spr_rs_id;
            wb_spr_reg_addr <= spr_reg_addr;
            wb_spr_result   <= spr_result;
        end
        if (cr_take) begin
            wb_cr_rs_id <= gpr_rs_id[sel];
            wb_cr_field <= cr0_field(gpr_result[sel], gpr_so[sel]);
        end
    end

endmodule

//--- hw/write_back_arbiter.sv
//****************************************
// Write-back arbiter top level
// Unit search, grant controller and
// result stage joined to plain ports
//****************************************

`timescale 1ns/1ps

module write_back_arbiter (
    input  logic                clk,
    input  logic                rst,

    // GPR producing units
    input  logic                gpr_valid     [0:wb_pkg::NUM_UNITS-1],
    output logic                gpr_ready     [0:wb_pkg::NUM_UNITS-1],
    input  wb_pkg::rs_id_t      gpr_rs_id     [0:wb_pkg::NUM_UNITS-1],
    input  wb_pkg::gpr_addr_t   gpr_reg_addr  [0:wb_pkg::NUM_UNITS-1],
    input  wb_pkg::word_t       gpr_result    [0:wb_pkg::NUM_UNITS-1],
    input  logic                gpr_xer_valid [0:wb_pkg::NUM_UNITS-1],
    input  wb_pkg::word_t       gpr_xer       [0:wb_pkg::NUM_UNITS-1],
    input  logic                gpr_cr0_valid [0:wb_pkg::NUM_UNITS-1],
    input  logic                gpr_so        [0:wb_pkg::NUM_UNITS-1],

    // SPR unit
    input  logic                spr_valid,
    output logic                spr_ready,
    input  wb_pkg::rs_id_t      spr_rs_id,
    input  wb_pkg::spr_addr_t   spr_reg_addr,
    input  wb_pkg::word_t       spr_result,

    // Register file write ports
    output logic                wb_gpr_valid,
    output wb_pkg::rs_id_t      wb_gpr_rs_id,
    output wb_pkg::gpr_addr_t   wb_gpr_reg_addr,
    output wb_pkg::word_t       wb_gpr_result,

    output logic                wb_spr_valid,
    output wb_pkg::rs_id_t      wb_spr_rs_id,
    output wb_pkg::spr_addr_t   wb_spr_reg_addr,
    output wb_pkg::word_t       wb_spr_result,

    output logic                wb_cr_valid,
    output wb_pkg::rs_id_t      wb_cr_rs_id,
    output wb_pkg::cr_field_t   wb_cr_field
);

    wb_search_if search_bus ();
    wb_grant_if  grant_bus ();

    wb_unit_search u_search (
        .clk           (clk),
        .rst           (rst),
        .gpr_valid     (gpr_valid),
        .gpr_xer_valid (gpr_xer_valid),
        .grant         (grant_bus.search),
        .found         (search_bus.search)
    );

    wb_grant_ctrl u_grant (
        .clk       (clk),
        .rst       (rst),
        .spr_valid (spr_valid),
        .found     (search_bus.ctrl),
        .grant     (grant_bus.ctrl)
    );

    wb_result_stage u_stage (
        .clk (clk), .rst (rst), .grant (grant_bus.stage),
        .gpr_rs_id (gpr_rs_id), .gpr_reg_addr (gpr_reg_addr),
        .gpr_result (gpr_result), .gpr_xer_valid (gpr_xer_valid),
        .gpr_xer (gpr_xer), .gpr_cr0_valid (gpr_cr0_valid),
        .gpr_so (gpr_so), .gpr_ready (gpr_ready),
        .spr_rs_id (spr_rs_id), .spr_reg_addr (spr_reg_addr),
        .spr_result (spr_result), .spr_ready (spr_ready),
        .wb_gpr_valid (wb_gpr_valid), .wb_gpr_rs_id (wb_gpr_rs_id),
        .wb_gpr_reg_addr (wb_gpr_reg_addr), .wb_gpr_result (wb_gpr_result),
        .wb_spr_valid (wb_spr_valid), .wb_spr_rs_id (wb_spr_rs_id),
        .wb_spr_reg_addr (wb_spr_reg_addr), .wb_spr_result (wb_spr_result),
        .wb_cr_valid (wb_cr_valid), .wb_cr_rs_id (wb_cr_rs_id),
        .wb_cr_field (wb_cr_field)
    );

endmodule

//--- tb/wb_arbiter_assert.sv
//****************************************
// Checks bound to the arbiter top level
// One-hot GPR ready, no SPR ready beside
// an XER update, SPR served on its turn,
// valids low after reset
//****************************************

`timescale 1ns/1ps

module wb_arbiter_assert (
    input logic clk,
    input logic rst,
    input logic gpr_ready     [0:wb_pkg::NUM_UNITS-1],
    input logic gpr_xer_valid [0:wb_pkg::NUM_UNITS-1],
    input logic spr_valid,
    input logic spr_ready,
    input logic spr_turn,
    input logic wb_gpr_valid,
    input logic wb_spr_valid,
    input logic wb_cr_valid
);
    import wb_pkg::*;

    int          ready_count;
    logic        xer_clash;
    int unsigned fail_count = 0;

    always_comb begin
        ready_count = 0;
        xer_clash   = 1'b0;
        for (int i = 0; i < NUM_UNITS; i++) begin
            if (gpr_ready[i]) begin
                ready_count++;
            end
            // SPR port would carry two writes
            if (gpr_ready[i] && gpr_xer_valid[i] && spr_ready) begin
                xer_clash = 1'b1;
            end
        end
    end

    one_gpr_ready: assert property (@(posedge clk) disable iff (rst) ready_count <= 1)
        else begin
            $error("more than one GPR unit is ready in the same cycle");
            fail_count++;
        end

    no_spr_port_clash: assert property (@(posedge clk) disable iff (rst) !xer_clash)
        else begin
            $error("SPR result granted together with an XER update");
            fail_count++;
        end

    // A waiting SPR result is taken when the turn flag is set
    spr_served_on_turn: assert property (@(posedge clk) disable iff (rst)
        (spr_turn && spr_valid) |-> spr_ready)
        else begin
            $error("SPR unit not served although the turn flag is set");
            fail_count++;
        end

    valids_low_after_reset: assert property (@(posedge clk)
        rst |=> (!wb_gpr_valid && !wb_spr_valid && !wb_cr_valid))
        else begin
            $error("write-back valid high in the cycle after reset");
            fail_count++;
        end

endmodule

bind write_back_arbiter wb_arbiter_assert u_assert (
    .clk           (clk),
    .rst           (rst),
    .gpr_ready     (gpr_ready),
    .gpr_xer_valid (gpr_xer_valid),
    .spr_valid     (spr_valid),
    .spr_ready     (spr_ready),
    .spr_turn      (grant_bus.spr_turn),
    .wb_gpr_valid  (wb_gpr_valid),
    .wb_spr_valid  (wb_spr_valid),
    .wb_cr_valid   (wb_cr_valid)
);

//--- tb/tb_write_back_arbiter.sv
//****************************************
// Testbench for the write-back arbiter
// Clock, reset, reference model of the
// grant and output rules, directed tests,
// timeout and summary
//****************************************

`timescale 1ns/1ps

module tb_write_back_arbiter;
    import wb_pkg::*;

    localparam int SEED          = 71;
    localparam int RANDOM_CYCLES = 400;
    // Directed part needs well under 100 cycles, random part 400 plus drain
    localparam int MAX_CYCLES    = 3000;

    logic      clk;
    logic      rst;
    logic      gpr_valid     [0:NUM_UNITS-1];
    logic      gpr_ready     [0:NUM_UNITS-1];
    rs_id_t    gpr_rs_id     [0:NUM_UNITS-1];
    gpr_addr_t gpr_reg_addr  [0:NUM_UNITS-1];
    word_t     gpr_result    [0:NUM_UNITS-1];
    logic      gpr_xer_valid [0:NUM_UNITS-1];
    word_t     gpr_xer       [0:NUM_UNITS-1];
    logic      gpr_cr0_valid [0:NUM_UNITS-1];
    logic      gpr_so        [0:NUM_UNITS-1];
    logic      spr_valid;
    logic      spr_ready;
    rs_id_t    spr_rs_id;
    spr_addr_t spr_reg_addr;
    word_t     spr_result;
    logic      wb_gpr_valid;
    rs_id_t    wb_gpr_rs_id;
    gpr_addr_t wb_gpr_reg_addr;
    word_t     wb_gpr_result;
    logic      wb_spr_valid;
    rs_id_t    wb_spr_rs_id;
    spr_addr_t wb_spr_reg_addr;
    word_t     wb_spr_result;
    logic      wb_cr_valid;
    rs_id_t    wb_cr_rs_id;
    cr_field_t wb_cr_field;

    int   errors      = 0;
    int   checks      = 0;
    int   cycle_count = 0;
    // Model of the round-robin pointer and the SPR turn flag
    int   m_ptr       = 0;
    logic m_turn      = 1'b0;

    write_back_arbiter u_dut (.*);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= MAX_CYCLES) begin
            $display("Timeout, the run did not finish within %0d cycles", MAX_CYCLES);
            $display("TEST FAILED");
            $finish;
        end
    end

    task automatic compare(input string test, input string field,
                           input logic [31:0] exp, input logic [31:0] act);
        checks++;
        if (exp !== act) begin
            errors++;
            $display("MISMATCH %s %s expected %0h actual %0h", test, field, exp, act);
        end
    endtask

    // CR0 from the result read as signed, SO copied behind the code
    function automatic cr_field_t expected_cr0(input word_t res, input logic so);
        if ($signed(res) < 0) begin
            return {CR_LT, so};
        end
        if (res == 32'd0) begin
            return {CR_EQ, so};
        end
        return {CR_GT, so};
    endfunction

    function automatic logic pending();
        logic p;
        p = spr_valid;
        for (int i = 0; i < NUM_UNITS; i++) begin
            p |= gpr_valid[i];
        end
        return p;
    endfunction

    task automatic offer_gpr(input int u, input rs_id_t rs, input gpr_addr_t addr,
                             input word_t res, input logic xer_v, input word_t xer,
                             input logic cr0_v, input logic so);
        gpr_valid[u]     = 1'b1;
        gpr_rs_id[u]     = rs;
        gpr_reg_addr[u]  = addr;
        gpr_result[u]    = res;
        gpr_xer_valid[u] = xer_v;
        gpr_xer[u]       = xer;
        gpr_cr0_valid[u] = cr0_v;
        gpr_so[u]        = so;
    endtask

    task automatic offer_spr(input rs_id_t rs, input spr_addr_t addr, input word_t res);
        spr_valid    = 1'b1;
        spr_rs_id    = rs;
        spr_reg_addr = addr;
        spr_result   = res;
    endtask

    // One clock: predict grants just before the rising edge, check outputs after it
    task automatic cycle(input string test);
        int                   idx;
        int                   next_idx;
        int                   clean_idx;
        int                   g_idx;
        logic                 any_hit;
        logic                 clean_hit;
        logic                 g_gpr;
        logic                 g_spr;
        logic                 x_take;
        logic                 c_take;
        logic [0:NUM_UNITS-1] exp_ready;
        logic [0:NUM_UNITS-1] dut_ready;

        #1;
        any_hit   = 1'b0;
        clean_hit = 1'b0;
        next_idx  = 0;
        clean_idx = 0;
        for (int k = 0; k < NUM_UNITS; k++) begin
            idx = (m_ptr + k) % NUM_UNITS;
            if (gpr_valid[idx] && !any_hit) begin
                next_idx = idx;
                any_hit  = 1'b1;
            end
            if (gpr_valid[idx] && !gpr_xer_valid[idx] && !clean_hit) begin
                clean_idx = idx;
                clean_hit = 1'b1;
            end
        end

        g_gpr = 1'b0;
        g_spr = 1'b0;
        g_idx = next_idx;
        if (!spr_valid) begin
            g_gpr = any_hit;
        end else if (m_turn) begin
            g_spr  = 1'b1;
            g_gpr  = clean_hit;
            g_idx  = clean_idx;
            m_turn = 1'b0;
        end else begin
            m_turn = 1'b1;
            if (clean_hit) begin
                g_gpr = 1'b1;
                g_idx = clean_idx;
                g_spr = 1'b1;
            end else if (any_hit) begin
                g_gpr = 1'b1;
            end else begin
                g_spr = 1'b1;
            end
        end
        if (g_gpr) begin
            m_ptr = g_idx;
        end

        for (int i = 0; i < NUM_UNITS; i++) begin
            exp_ready[i] = g_gpr && (g_idx == i);
            dut_ready[i] = gpr_ready[i];
        end
        compare(test, "gpr_ready", 32'(exp_ready), 32'(dut_ready));
        compare(test, "spr_ready", 32'(g_spr), 32'(spr_ready));

        // Inputs are unchanged until this task returns
        @(negedge clk);
        x_take = g_gpr && gpr_xer_valid[g_idx];
        c_take = g_gpr && gpr_cr0_valid[g_idx];
        compare(test, "wb_gpr_valid", 32'(g_gpr), 32'(wb_gpr_valid));
        if (g_gpr) begin
            compare(test, "wb_gpr_rs_id", 32'(gpr_rs_id[g_idx]), 32'(wb_gpr_rs_id));
            compare(test, "wb_gpr_reg_addr", 32'(gpr_reg_addr[g_idx]), 32'(wb_gpr_reg_addr));
            compare(test, "wb_gpr_result", gpr_result[g_idx], wb_gpr_result);
        end
        compare(test, "wb_spr_valid", 32'(x_take || g_spr), 32'(wb_spr_valid));
        if (x_take) begin
            compare(test, "wb_spr_rs_id", 32'(gpr_rs_id[g_idx]), 32'(wb_spr_rs_id));
            compare(test, "wb_spr_reg_addr", 32'(XER_ADDR), 32'(wb_spr_reg_addr));
            compare(test, "wb_spr_result", gpr_xer[g_idx], wb_spr_result);
        end else if (g_spr) begin
            compare(test, "wb_spr_rs_id", 32'(spr_rs_id), 32'(wb_spr_rs_id));
            compare(test, "wb_spr_reg_addr", 32'(spr_reg_addr), 32'(wb_spr_reg_addr));
            compare(test, "wb_spr_result", spr_result, wb_spr_result);
        end
        compare(test, "wb_cr_valid", 32'(c_take), 32'(wb_cr_valid));
        if (c_take) begin
            compare(test, "wb_cr_rs_id", 32'(gpr_rs_id[g_idx]), 32'(wb_cr_rs_id));
            compare(test, "wb_cr_field",
                    32'(expected_cr0(gpr_result[g_idx], gpr_so[g_idx])), 32'(wb_cr_field));
        end

        // Accepted producers drop valid
        if (g_gpr) begin
            gpr_valid[g_idx] = 1'b0;
        end
        if (g_spr) begin
            spr_valid = 1'b0;
        end
    endtask

    task automatic drain(input string test);
        while (pending()) begin
            cycle(test);
        end
    endtask

    task automatic single_gpr();
        offer_gpr(3, 5'h0a, 5'd7, 32'h1234_5678, 1'b0, '0, 1'b0, 1'b0);
        drain("single_gpr");
    endtask

    task automatic cr0_codes();
        word_t vals [0:2];
        vals[0] = 32'hfff0_0000;
        vals[1] = 32'h0000_0000;
        vals[2] = 32'h0000_0042;
        for (int v = 0; v < 3; v++) begin
            for (int s = 0; s < 2; s++) begin
                offer_gpr(v * 2 + s, rs_id_t'(16 + v * 2 + s), gpr_addr_t'(v), vals[v],
                          1'b0, '0, 1'b1, 1'(s));
                drain("cr0_codes");
            end
        end
    endtask

    task automatic xer_update();
        offer_gpr(5, 5'h13, 5'd3, 32'h7fff_ffff, 1'b1, 32'hc000_0000, 1'b1, 1'b1);
        drain("xer_update");
    endtask

    task automatic round_robin();
        for (int u = 0; u < NUM_UNITS; u++) begin
            if (u % 3 != 1) begin
                offer_gpr(u, rs_id_t'(u), gpr_addr_t'(u + 8), word_t'(u * 3),
                          1'b0, '0, 1'b0, 1'b0);
            end
        end
        drain("round_robin");
    endtask

    task automatic spr_contention();
        int   wait_cycles;
        logic spr_seen;
        for (int r = 0; r < 3; r++) begin
            if (!gpr_valid[0]) begin
                offer_gpr(0, 5'h01, 5'd1, 32'h10, 1'b1, 32'h2000_0000, 1'b0, 1'b0);
            end
            if (!gpr_valid[2]) begin
                offer_gpr(2, 5'h02, 5'd2, 32'h20, 1'b1, 32'h8000_0000, 1'b0, 1'b0);
            end
            // First round also has a unit that leaves the SPR port free
            if (r == 0) begin
                offer_gpr(5, 5'h05, 5'd5, 32'h50, 1'b0, '0, 1'b0, 1'b0);
            end
            offer_spr(rs_id_t'(20 + r), spr_addr_t'(256 + r), word_t'(32'hab00 + r));
            wait_cycles = 0;
            spr_seen    = 1'b0;
            // Watch the DUT's SPR port for this SPR result
            while (!spr_seen && wait_cycles <= 1) begin
                cycle("spr_contention");
                if (wb_spr_valid && wb_spr_reg_addr == spr_addr_t'(256 + r)) begin
                    spr_seen = 1'b1;
                end else begin
                    wait_cycles++;
                end
            end
            checks++;
            if (!spr_seen) begin
                errors++;
                $display("SPR unit waited more than one turn for its write-back");
            end
        end
        drain("spr_contention");
    endtask

    task automatic random_mix();
        logic [31:0] rnd;
        word_t       res;
        for (int n = 0; n < RANDOM_CYCLES; n++) begin
            for (int u = 0; u < NUM_UNITS; u++) begin
                rnd = $urandom;
                // Zero results now and then to reach the EQ code
                res = (rnd[5:4] == 2'b00) ? '0 : word_t'($urandom);
                if (!gpr_valid[u] && rnd[0]) begin
                    offer_gpr(u, rs_id_t'($urandom), gpr_addr_t'($urandom), res,
                              rnd[1], word_t'($urandom), rnd[2], rnd[3]);
                end
            end
            rnd = $urandom;
            if (!spr_valid && rnd[0]) begin
                offer_spr(rs_id_t'($urandom), spr_addr_t'($urandom), word_t'($urandom));
            end
            cycle("random_mix");
        end
        drain("random_mix");
    endtask

    initial begin
        void'($urandom(SEED));
        rst          = 1'b1;
        spr_valid    = 1'b0;
        spr_rs_id    = '0;
        spr_reg_addr = '0;
        spr_result   = '0;
        for (int i = 0; i < NUM_UNITS; i++) begin
            offer_gpr(i, '0, '0, '0, 1'b0, '0, 1'b0, 1'b0);
            gpr_valid[i] = 1'b0;
        end
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        compare("reset", "wb_gpr_valid", 32'd0, 32'(wb_gpr_valid));
        compare("reset", "wb_spr_valid", 32'd0, 32'(wb_spr_valid));
        compare("reset", "wb_cr_valid", 32'd0, 32'(wb_cr_valid));

        single_gpr();
        cr0_codes();
        xer_update();
        round_robin();
        spr_contention();
        random_mix();

        errors += int'(u_dut.u_assert.fail_count);
        $display("Checks: %0d  errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

//--- write_back.f
common/wb_pkg.sv
common/wb_search_if.sv
common/wb_grant_if.sv
hw/wb_unit_search.sv
hw/wb_grant_ctrl.sv
hw/wb_result_stage.sv
hw/write_back_arbiter.sv
tb/wb_arbiter_assert.sv
tb/tb_write_back_arbiter.sv

//--- run.sh
#!/bin/sh
# Build the write-back arbiter testbench with Verilator and run it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
    --top-module tb_write_back_arbiter \
    -f write_back.f -o tb_write_back_arbiter

# Assertion errors are counted by the testbench instead of stopping the run
out=$(./obj_dir/tb_write_back_arbiter +verilator+error+limit+1000)
echo "$out"
echo "$out" | grep -qx "TEST OK"
